/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_top
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard rtl/*.sv dv/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/cpu_checker.sv */
// Watches uo_out, halted and the fixed uio pins; expected values and halt latency are valid from each start pulse
`timescale 1ns/1ps

module cpu_checker (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] uo_out,
    input  logic       halted,
    input  logic [6:0] uio_low,                             // uio_out[6:0], always zero
    input  logic [7:0] uio_oe,                              // Fixed output enable
    input  logic       run,
    input  logic       start,                               // New program about to run
    input  logic [7:0] exp_vals [64],
    input  int         exp_n,
    input  int         exp_cycles,                          // Clock after run rise to halted
    output int         value_errs,
    output int         cycle_errs,
    output int         other_errs,
    output logic       stuck
);

    logic       started;                                    // A program has been started
    logic       run_q;
    logic       done;                                       // Halt already checked this run
    logic [7:0] seen;
    int         idx;
    int         cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        int other_add;                                      // Failures found this cycle
        if (!rst_n) begin
            started    <= 1'b0;
            run_q      <= 1'b0;
            done       <= 1'b0;
            seen       <= 8'h00;
            idx        <= 0;
            cnt        <= 0;
            stuck      <= 1'b0;
            value_errs <= 0;
            cycle_errs <= 0;
            other_errs <= 0;
        end else begin
            other_add = 0;
            run_q <= run;
            if (!run && halted) begin
                $display("FAILED %0t halted is high while run is low", $time);
                other_add = other_add + 1;
            end
            if (uio_low != 7'd0 || uio_oe != 8'h80) begin  // Only bit 7 is a live output
                $display("FAILED %0t uio_out[6:0] 0x%02h, uio_oe 0x%02h, expected 0x00 and 0x80",
                         $time, uio_low, uio_oe);
                other_add = other_add + 1;
            end
            if (!started && uo_out != 8'h00) begin          // Reset state
                $display("FAILED %0t uo_out 0x%02h after reset, expected 0x00", $time, uo_out);
                other_add = other_add + 1;
            end
            if (start) begin
                started <= 1'b1;
                idx     <= 0;
                cnt     <= 0;
                done    <= 1'b0;
                stuck   <= 1'b0;
                seen    <= uo_out;
            end else if (started) begin
                if (uo_out != seen) begin                   // Each change is one OUT
                    seen <= uo_out;
                    idx  <= idx + 1;
                    if (idx >= exp_n) begin
                        $display("FAILED %0t unexpected output 0x%02h", $time, uo_out);
                        value_errs <= value_errs + 1;
                    end else if (uo_out != exp_vals[idx]) begin
                        $display("FAILED %0t output 0x%02h, expected 0x%02h",
                                 $time, uo_out, exp_vals[idx]);
                        value_errs <= value_errs + 1;
                    end
                end
                if (run && run_q && !halted) begin
                    cnt <= cnt + 1;
                end
                if (run && halted && !done) begin
                    done <= 1'b1;
                    if (cnt != exp_cycles) begin
                        $display("FAILED %0t halt after %0d cycles, expected %0d",
                                 $time, cnt, exp_cycles);
                        cycle_errs <= cycle_errs + 1;
                    end
                    if (idx < exp_n) begin
                        $display("Missing outputs: saw %0d of %0d values before halt",
                                 idx, exp_n);
                        other_add = other_add + 1;
                    end
                end
                if (run && done && !halted) begin           // Halt is sticky until run falls
                    $display("FAILED %0t halted fell while run is still high", $time);
                    other_add = other_add + 1;
                end
                if (run && !halted && !stuck && cnt > exp_cycles + 20) begin
                    $display("halted did not rise within %0d cycles of run", cnt);
                    other_add = other_add + 1;
                    stuck     <= 1'b1;              // Lets the driver drop run
                end
            end
            other_errs <= other_errs + other_add;
        end
    end

endmodule

/* dv/tb_top.sv */
// CPU testbench; expected results come from an ISA model whose A, flags and RAM persist across programs
`timescale 1ns/1ps

module tb_top;

    localparam int step_limit = 64;                         // Model instruction budget
    localparam int n_programs = 21;                         // 1 + 6 + 2 + 2 + 10
    localparam int cycle_limit = n_programs * (16 + 5 * step_limit + 10) + 40;

    logic       clk;
    logic       rst_n;
    logic [7:0] ui_in;
    logic [7:0] uio_in;                                     // [3:0] addr, [4] we, [5] run
    logic       ena;
    logic [7:0] uo_out;
    logic [7:0] uio_out;
    logic [7:0] uio_oe;

    logic       start;                                      // One-cycle pulse to the checker
    logic       stuck;
    int         value_errs;
    int         cycle_errs;
    int         other_errs;
    int         model_errs;
    int         cycles;

    // Model state carried from program to program
    logic [7:0] st_mem [16];
    logic [7:0] st_a;
    logic       st_cf;
    logic       st_zf;
    logic [7:0] st_last;                                    // Last value seen on uo_out
    logic [7:0] tr_mem [16];                                // Trial copy used by one model run
    logic [7:0] tr_a;
    logic       tr_cf;
    logic       tr_zf;
    logic [7:0] tr_last;
    logic [7:0] prog [16];                                  // Image to load next
    logic [7:0] exp_vals [64];
    int         exp_n;
    int         exp_k;                                      // Instructions before the HLT
    int         exp_cycles;
    logic [31:0] rng;

    tt_um_8_bit_cpu_top i_tt_um_8_bit_cpu_top (
        .ui_in   (ui_in),
        .uo_out  (uo_out),
        .uio_in  (uio_in),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .ena     (ena),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    cpu_checker i_cpu_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .uo_out     (uo_out),
        .halted     (uio_out[7]),
        .uio_low    (uio_out[6:0]),
        .uio_oe     (uio_oe),
        .run        (uio_in[5]),
        .start      (start),
        .exp_vals   (exp_vals),
        .exp_n      (exp_n),
        .exp_cycles (exp_cycles),
        .value_errs (value_errs),
        .cycle_errs (cycle_errs),
        .other_errs (other_errs),
        .stuck      (stuck)
    );

    always #4 clk = ~clk;                                   // 8 ns period

    // Global watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // ISA model; returns 1 if HLT is reached within step_limit
    function automatic bit ref_run();
        logic [7:0] ir;
        logic [3:0] pc;
        logic [3:0] opnd;
        logic [8:0] sum;
        int         steps;
        bit         done;
        tr_mem  = st_mem;
        tr_a    = st_a;
        tr_cf   = st_cf;
        tr_zf   = st_zf;
        tr_last = st_last;
        pc      = 4'd0;
        exp_n   = 0;
        exp_k   = 0;
        steps   = 0;
        done    = 1'b0;
        while (!done && steps < step_limit) begin
            ir    = tr_mem[pc];
            opnd  = ir[3:0];
            pc    = pc + 4'd1;                              // Wraps past 15
            steps = steps + 1;
            case (ir[7:4])
                4'd1: tr_a = tr_mem[opnd];
                4'd2: sum = {1'b0, tr_a} + {1'b0, tr_mem[opnd]};
                4'd3: sum = {1'b0, tr_a} + {1'b0, ~tr_mem[opnd]} + 9'd1;
                4'd4: tr_mem[opnd] = tr_a;
                4'd5: tr_a = {4'd0, opnd};
                4'd6: pc = opnd;
                4'd7: if (tr_cf) pc = opnd;
                4'd8: if (tr_zf) pc = opnd;
                4'd14: begin
                    if (tr_a != tr_last) begin              // Only changes are visible
                        exp_vals[exp_n] = tr_a;
                        exp_n           = exp_n + 1;
                        tr_last         = tr_a;
                    end
                end
                4'd15: done = 1'b1;
                default: ;                                  // NOP and spare codes
            endcase
            if (ir[7:4] == 4'd2 || ir[7:4] == 4'd3) begin
                tr_a  = sum[7:0];
                tr_cf = sum[8];
                tr_zf = (sum[7:0] == 8'd0);
            end
        end
        exp_k = steps - 1;
        return done;
    endfunction

    // Writes the bytes selected by mask, one prog_we pulse each
    task automatic load_program(input logic [15:0] mask);
        for (int i = 0; i < 16; i++) begin
            if (mask[i]) begin
                @(posedge clk);
                ui_in     <= prog[i];
                uio_in    <= {3'b000, 1'b1, 4'(i)};
                st_mem[i] = prog[i];
            end
        end
        @(posedge clk);
        uio_in <= 8'h00;
    endtask

    task automatic run_program(input logic [15:0] mask);
        bit ok;
        load_program(mask);
        ok = ref_run();
        if (!ok) begin
            $display("Model did not reach HLT on a directed program");
            model_errs = model_errs + 1;
        end else begin
            st_mem     = tr_mem;
            st_a       = tr_a;
            st_cf      = tr_cf;
            st_zf      = tr_zf;
            st_last    = tr_last;
            exp_cycles = 5 * exp_k + 3;
            @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start  <= 1'b0;
            uio_in <= 8'h20;                                // Raise run
            do @(posedge clk); while (!uio_out[7] && !stuck);
            repeat (2) @(posedge clk);                      // halted must hold while run stays high
            uio_in <= 8'h00;
            repeat (3) @(posedge clk);
        end
    endtask

    initial begin
        logic [31:0] r;
        bit          ok;
        clk        = 1'b0;
        rst_n      = 1'b0;
        ui_in      = 8'h00;
        uio_in     = 8'h00;
        ena        = 1'b1;
        start      = 1'b0;
        cycles     = 0;
        model_errs = 0;
        rng        = 32'haa95;
        st_a       = 8'h00;
        st_cf      = 1'b0;
        st_zf      = 1'b0;
        st_last    = 8'h00;
        exp_n      = 0;
        exp_k      = 0;
        exp_cycles = 0;
        for (int i = 0; i < 64; i++) exp_vals[i] = 8'h00;
        for (int i = 0; i < 16; i++) st_mem[i] = 8'h00;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);                          // Idle, checker watches reset state

        // Straight-line arithmetic
        r = next_rand();
        prog = '{8'h1D, 8'h2E, 8'hE0, 8'h3C, 8'hE0, 8'h4F, {4'h5, r[3:0]}, 8'hE0,
                 8'h2F, 8'hE0, 8'hF0, 8'h00, r[15:8], r[23:16], r[31:24], 8'h00};
        run_program(16'hFFFF);

        // Carry and zero flags steering JC and JZ
        for (int n = 0; n < 6; n++) begin
            r = next_rand();
            prog = '{8'h1E, 8'h2F, 8'h75, 8'h51, 8'h66, 8'h52, 8'hE0, 8'h8A,
                     8'h53, 8'h6B, 8'h54, 8'hE0, 8'hF0, 8'h00, r[15:8], r[23:16]};
            if (n[0]) prog[1] = 8'h3F;                      // SUB on odd passes
            if (n[1]) prog[15] = r[15:8];                   // Equal operands hit ZF
            if (n == 5) begin
                prog[1]  = 8'h2F;                           // ADD to exactly 256
                prog[15] = 8'd0 - r[15:8];
            end
            run_program(16'hFFFF);
        end

        // Count-down loop
        for (int n = 0; n < 2; n++) begin
            r = next_rand();
            prog = '{8'h1E, 8'hE0, 8'h3F, 8'h85, 8'h61, 8'hE0, 8'hF0, 8'h00,
                     8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
                     8'd3 + {5'd0, r[2:0]}, 8'd1};
            run_program(16'hFFFF);
        end

        // Rewrite with a store left in place at address 15
        prog = '{8'h59, 8'h4F, 8'h53, 8'hE0, 8'hF0, 8'h00, 8'h00, 8'h00,
                 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
        run_program(16'hFFFF);
        prog = '{8'h1F, 8'hE0, 8'hF0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
                 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
        run_program(16'h7FFF);

        // Random programs with a forced HLT at the end
        for (int n = 0; n < 10; n++) begin
            do begin
                for (int i = 0; i < 15; i++) begin
                    r = next_rand();
                    prog[i] = r[31:24];
                end
                prog[15] = 8'hF0;
                st_mem   = prog;
                ok       = ref_run();
            end while (!ok);
            run_program(16'hFFFF);
        end

        $display("Errors: value %0d, cycle %0d, other %0d, model %0d",
                 value_errs, cycle_errs, other_errs, model_errs);
        if (value_errs + cycle_errs + other_errs + model_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* filelist.f */
rtl/cpu_pkg.sv
rtl/program_counter.sv
rtl/control_block.sv
rtl/alu.sv
rtl/ram_mar.sv
rtl/datapath_regs.sv
rtl/tt_um_8_bit_cpu_top.sv
dv/cpu_checker.sv
dv/tb_top.sv

/* rtl/alu.sv */
// Combinational add/subtract of A and B; carry and zero flags are stored only on flags_load
`timescale 1ns/1ps

module alu
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [data_w-1:0] a,
    input  logic [data_w-1:0] b,
    input  logic              sub,          // 1 gives A - B in two's complement
    input  logic              flags_load,
    output logic [data_w-1:0] result,
    output logic              cf,
    output logic              zf
);

    logic [data_w-1:0] b_eff;               // B or its ones' complement
    logic [data_w:0]   sum;                 // Extra bit catches carry out of bit 7

    assign b_eff  = sub ? ~b : b;
    assign sum    = {1'b0, a} + {1'b0, b_eff} + {{data_w{1'b0}}, sub}; // Plus one on SUB
    assign result = sum[data_w-1:0];

    // Flags reflect the last ADD or SUB only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cf <= 1'b0;
            zf <= 1'b0;
        end else if (flags_load) begin
            cf <= sum[data_w];              // On SUB set means no borrow
            zf <= (result == '0);
        end
    end

endmodule

/* rtl/control_block.sv */
// Five-state microcode sequencer; the first cycle with run high only clears the PC, so fetch starts one clock later
`timescale 1ns/1ps

module control_block
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     run,                   // Level, synchronous to clk
    input  opcode_e  opcode,                // From the instruction register
    input  logic     cf,                    // Stored carry flag
    input  logic     zf,                    // Stored zero flag
    output bus_src_e bus_src,
    output logic     pc_clear,
    output logic     pc_inc,
    output logic     pc_load,
    output logic     mar_load,
    output logic     ram_store,
    output logic     ir_load,
    output logic     a_load,
    output logic     b_load,
    output logic     alu_sub,
    output logic     flags_load,
    output logic     out_load,
    output logic     halted
);

    logic [t_w-1:0] t_q;                    // Current T-state
    logic           run_q;                  // Run seen on the previous clock
    logic           halted_q;
    logic           active;                 // Sequencer is stepping this cycle
    logic           halt_set;               // HLT decoded at T2

    // Running only once run has been high for a full clock and no HLT yet
    assign active = run & run_q & ~halted_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            t_q      <= '0;
            run_q    <= 1'b0;
            halted_q <= 1'b0;
        end else begin
            run_q <= run;
            if (!run) begin
                t_q      <= '0;             // Idle parked at T0
                halted_q <= 1'b0;           // Falling run releases the halt
            end else if (active) begin
                t_q <= (t_q == t_last) ? '0 : t_q + t_w'(1);
                if (halt_set) begin
                    halted_q <= 1'b1;
                end
            end
        end
    end

    // PC held at zero while stopped and during the start cycle
    assign pc_clear = ~(run & run_q);
    assign halted   = halted_q & run;       // Reads 0 as soon as run drops

    // Microcode table
    always_comb begin
        bus_src    = src_none;
        pc_inc     = 1'b0;
        pc_load    = 1'b0;
        mar_load   = 1'b0;
        ram_store  = 1'b0;
        ir_load    = 1'b0;
        a_load     = 1'b0;
        b_load     = 1'b0;
        alu_sub    = 1'b0;
        flags_load = 1'b0;
        out_load   = 1'b0;
        halt_set   = 1'b0;
        if (active) begin
            case (t_q)
                t_w'(0): begin              // Fetch address
                    bus_src  = src_pc;
                    mar_load = 1'b1;
                end
                t_w'(1): begin              // Fetch instruction byte
                    bus_src = src_ram;
                    ir_load = 1'b1;
                    pc_inc  = 1'b1;
                end
                t_w'(2): begin
                    case (opcode)
                        op_lda, op_add, op_sub, op_sta: begin
                            bus_src  = src_ir_operand;  // Data address into MAR
                            mar_load = 1'b1;
                        end
                        op_ldi: begin
                            bus_src = src_ir_operand;
                            a_load  = 1'b1;
                        end
                        op_jmp: begin
                            bus_src = src_ir_operand;
                            pc_load = 1'b1;
                        end
                        op_jc: begin
                            bus_src = src_ir_operand;
                            pc_load = cf;   // Not taken falls through to next byte
                        end
                        op_jz: begin
                            bus_src = src_ir_operand;
                            pc_load = zf;
                        end
                        op_out: begin
                            bus_src  = src_acc;
                            out_load = 1'b1;
                        end
                        op_hlt:  halt_set = 1'b1;
                        default: ;          // NOP and unused codes
                    endcase
                end
                t_w'(3): begin
                    case (opcode)
                        op_lda: begin
                            bus_src = src_ram;
                            a_load  = 1'b1;
                        end
                        op_add, op_sub: begin
                            bus_src = src_ram;      // Second operand into B
                            b_load  = 1'b1;
                        end
                        op_sta: begin
                            bus_src   = src_acc;
                            ram_store = 1'b1;
                        end
                        default: ;
                    endcase
                end
                t_w'(4): begin
                    if (opcode == op_add || opcode == op_sub) begin
                        bus_src    = src_alu;
                        a_load     = 1'b1;
                        flags_load = 1'b1;
                        alu_sub    = (opcode == op_sub);
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

/* rtl/cpu_pkg.sv */
// Shared sizes and encodings for the 8-bit accumulator CPU; sizes are fixed, not tunable per instance
package cpu_pkg;

    // Datapath and memory sizes
    localparam int data_w    = 8;           // Bus, registers and RAM words
    localparam int addr_w    = 4;           // RAM address and PC width
    localparam int ram_words = 16;          // 2**addr_w bytes of flip-flop RAM

    // Sequencer timing
    localparam int t_states  = 5;           // T0 fetch addr, T1 fetch, T2..T4 execute
    localparam int t_w       = 3;           // Wide enough for t_states - 1
    localparam logic [t_w-1:0] t_last = t_w'(t_states - 1);

    // Instruction opcodes, high nibble of each byte
    // Unlisted codes decode as no-op
    typedef enum logic [3:0] {
        op_nop = 4'd0,
        op_lda = 4'd1,                      // A <= RAM[operand]
        op_add = 4'd2,                      // A <= A + RAM[operand]
        op_sub = 4'd3,                      // A <= A - RAM[operand]
        op_sta = 4'd4,                      // RAM[operand] <= A
        op_ldi = 4'd5,                      // A <= operand, zero-extended
        op_jmp = 4'd6,
        op_jc  = 4'd7,                      // Jump if carry flag set
        op_jz  = 4'd8,                      // Jump if zero flag set
        op_out = 4'd14,                     // Output register <= A
        op_hlt = 4'd15
    } opcode_e;

    // Who drives the internal bus this cycle
    typedef enum logic [2:0] {
        src_none       = 3'd0,              // Bus reads as zero
        src_pc         = 3'd1,
        src_ram        = 3'd2,
        src_ir_operand = 3'd3,
        src_acc        = 3'd4,
        src_alu        = 3'd5
    } bus_src_e;

endpackage

/* rtl/datapath_regs.sv */
// Bus-loaded IR, A, B and output registers; all clear on reset and load only on their own strobe
`timescale 1ns/1ps

module datapath_regs
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [data_w-1:0] bus,
    input  logic              ir_load,
    input  logic              a_load,
    input  logic              b_load,
    input  logic              out_load,
    output opcode_e           opcode,       // IR high nibble
    output logic [addr_w-1:0] operand,      // IR low nibble
    output logic [data_w-1:0] a,
    output logic [data_w-1:0] b,
    output logic [data_w-1:0] out_value
);

    logic [data_w-1:0] ir_q;
    logic [data_w-1:0] a_q;
    logic [data_w-1:0] b_q;
    logic [data_w-1:0] out_q;

    // Instruction register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir_q <= '0;                     // Decodes as NOP
        end else if (ir_load) begin
            ir_q <= bus;
        end
    end

    // Accumulator
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_q <= '0;
        end else if (a_load) begin
            a_q <= bus;                     // LDA, LDI or ALU result
        end
    end

    // B register, ALU second operand
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            b_q <= '0;
        end else if (b_load) begin
            b_q <= bus;
        end
    end

    // Output register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_q <= '0;
        end else if (out_load) begin
            out_q <= bus;                   // Visible on pins the cycle after OUT's T2
        end
    end

    // Split the instruction byte
    assign opcode    = opcode_e'(ir_q[data_w-1:addr_w]);
    assign operand   = ir_q[addr_w-1:0];

    assign a         = a_q;
    assign b         = b_q;
    assign out_value = out_q;

    // Unused IR codes pass through as-is and the sequencer treats them as NOP
    // The operand nibble doubles as address, immediate and jump target

endmodule

/* rtl/program_counter.sv */
// 4-bit fetch address; clear beats load beats increment, and increment wraps from 15 to 0
`timescale 1ns/1ps

module program_counter
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clear,        // Held while the CPU is stopped
    input  logic              inc,          // T1 of every instruction
    input  logic              load,         // Taken jump
    input  logic [addr_w-1:0] load_value,   // Jump target from the bus low nibble
    output logic [addr_w-1:0] pc
);

    logic [addr_w-1:0] pc_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (clear) begin
            pc_q <= '0;
        end else if (load) begin
            pc_q <= load_value;
        end else if (inc) begin
            pc_q <= pc_q + addr_w'(1);      // Natural wrap at the top of memory
        end
    end

    assign pc = pc_q;

endmodule

/* rtl/ram_mar.sv */
// 16-byte flip-flop RAM behind the MAR; contents are undefined until written, and a store wins over a program write
`timescale 1ns/1ps

module ram_mar
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [data_w-1:0] bus,
    input  logic              mar_load,     // Capture address from bus low nibble
    input  logic              store,        // STA write at the MAR
    input  logic              prog_we,      // External loader, gated by the top
    input  logic [addr_w-1:0] prog_addr,
    input  logic [data_w-1:0] prog_data,
    output logic [data_w-1:0] rdata
);

    logic [addr_w-1:0] mar_q;
    logic [data_w-1:0] mem [ram_words];

    // Memory address register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mar_q <= '0;
        end else if (mar_load) begin
            mar_q <= bus[addr_w-1:0];
        end
    end

    // Single write port shared by run-time stores and the loader
    always_ff @(posedge clk) begin
        if (store) begin
            mem[mar_q] <= bus;
        end else if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    assign rdata = mem[mar_q];              // Asynchronous read

endmodule

/* rtl/tt_um_8_bit_cpu_top.sv */
// TinyTapeout top; uio[5:0] are inputs (address, write strobe, run), uio[7] outputs halted, and ena is ignored
`timescale 1ns/1ps

module tt_um_8_bit_cpu_top
    import cpu_pkg::*;
(
    input  logic [7:0] ui_in,               // Program data byte
    output logic [7:0] uo_out,              // Output register
    input  logic [7:0] uio_in,              // [3:0] addr, [4] prog_we, [5] run
    output logic [7:0] uio_out,             // [7] halted
    output logic [7:0] uio_oe,
    input  logic       ena,
    input  logic       clk,
    input  logic       rst_n
);

    // Pin decode
    logic              run;
    logic              prog_we;
    logic [addr_w-1:0] prog_addr;

    assign run       = uio_in[5];
    assign prog_addr = uio_in[addr_w-1:0];
    assign prog_we   = uio_in[4] & ~run;    // Loader locked out while running

    // Internal bus and its sources
    logic [data_w-1:0] bus;
    logic [addr_w-1:0] pc;
    logic [data_w-1:0] ram_rdata;
    logic [addr_w-1:0] operand;
    logic [data_w-1:0] reg_a;
    logic [data_w-1:0] reg_b;
    logic [data_w-1:0] alu_result;
    logic [data_w-1:0] out_value;

    // Control strobes
    bus_src_e bus_src;
    opcode_e  opcode;
    logic     pc_clear;
    logic     pc_inc;
    logic     pc_load;
    logic     mar_load;
    logic     ram_store;
    logic     ir_load;
    logic     a_load;
    logic     b_load;
    logic     alu_sub;
    logic     flags_load;
    logic     out_load;
    logic     halted;
    logic     cf;                           // Stored carry
    logic     zf;                           // Stored zero

    // Bus mux, one source per cycle
    always_comb begin
        case (bus_src)
            src_pc:         bus = {{(data_w-addr_w){1'b0}}, pc};
            src_ram:        bus = ram_rdata;
            src_ir_operand: bus = {{(data_w-addr_w){1'b0}}, operand};
            src_acc:        bus = reg_a;
            src_alu:        bus = alu_result;
            default:        bus = '0;       // Nobody driving
        endcase
    end

    control_block i_control_block (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .opcode     (opcode),
        .cf         (cf),
        .zf         (zf),
        .bus_src    (bus_src),
        .pc_clear   (pc_clear),
        .pc_inc     (pc_inc),
        .pc_load    (pc_load),
        .mar_load   (mar_load),
        .ram_store  (ram_store),
        .ir_load    (ir_load),
        .a_load     (a_load),
        .b_load     (b_load),
        .alu_sub    (alu_sub),
        .flags_load (flags_load),
        .out_load   (out_load),
        .halted     (halted)
    );

    program_counter i_program_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (pc_clear),
        .inc        (pc_inc),
        .load       (pc_load),
        .load_value (bus[addr_w-1:0]),      // Jump target
        .pc         (pc)
    );

    ram_mar i_ram_mar (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus),
        .mar_load  (mar_load),
        .store     (ram_store),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (ui_in),
        .rdata     (ram_rdata)
    );

    datapath_regs i_datapath_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus),
        .ir_load   (ir_load),
        .a_load    (a_load),
        .b_load    (b_load),
        .out_load  (out_load),
        .opcode    (opcode),
        .operand   (operand),
        .a         (reg_a),
        .b         (reg_b),
        .out_value (out_value)
    );

    alu i_alu (
        .clk        (clk),
        .rst_n      (rst_n),
        .a          (reg_a),
        .b          (reg_b),
        .sub        (alu_sub),
        .flags_load (flags_load),
        .result     (alu_result),
        .cf         (cf),
        .zf         (zf)
    );

    // Pin mapping
    assign uo_out  = out_value;
    assign uio_out = {halted, 7'b0};
    assign uio_oe  = 8'h80;                 // Only bit 7 drives

endmodule
